// File: verilog/tc_prot_pkg.sv
// NB1412M2 protection model shared definitions
// register map, opcodes, sequencer states and bus structs

package tc_prot_pkg;

    // ==================================================
    // bus and protection constants
    // ==================================================
    localparam int AXI_ADDR_W = 16;
    localparam int AXI_DATA_W = 32;
    localparam int ROM_WIN_BIT = 15;

    localparam logic [7:0] PROT_KEY = 8'h43;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // register offsets, status bit 0 is busy
    typedef enum logic [15:0] {
        REG_CMD    = 16'h0000,
        REG_DATA   = 16'h0004,
        REG_DAC1   = 16'h0008,
        REG_DAC2   = 16'h000C,
        REG_STATUS = 16'h0010
    } reg_addr_e;

    // protection opcodes
    typedef enum logic [7:0] {
        CMD_ROM_HI = 8'h33,
        CMD_ROM_LO = 8'h34,
        CMD_ADJ_HI = 8'h35,
        CMD_ADJ_LO = 8'h36
    } prot_cmd_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_CAPTURE
    } fetch_state_e;

    // which holding register a fetch lands in
    typedef enum logic {
        TGT_ROM,
        TGT_ADJ
    } fetch_target_e;

    // ==================================================
    // structs
    // ==================================================
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  awvalid;
        logic [AXI_DATA_W-1:0] wdata;
        logic [3:0]            wstrb;
        logic                  wvalid;
        logic                  bready;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
    } axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic [1:0]            bresp;
        logic                  bvalid;
        logic                  arready;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic        en;
        logic [15:0] index;
        logic [7:0]  data;
    } rom_load_t;

    typedef struct packed {
        logic          en;
        fetch_target_e target;
    } capture_t;

    // sel 0 is dac1, sel 1 is dac2
    typedef struct packed {
        logic       en;
        logic       sel;
        logic [7:0] data;
    } dac_wr_t;

endpackage

// File: verilog/prot_rom.sv
// protection data ROM
// host-loaded single-clock RAM with a registered fetch port

module prot_rom
    import tc_prot_pkg::*;
#(
    parameter int ROM_DEPTH = 8192
) (
    input  logic        clk_24M,
    input  rom_load_t   rom_load,
    input  logic [15:0] fetch_addr,
    output logic [7:0]  rom_q
);

    localparam int ADDR_W = $clog2(ROM_DEPTH);

    logic [7:0]        mem [ROM_DEPTH];
    logic [ADDR_W-1:0] load_idx;
    logic [ADDR_W-1:0] rd_idx;

    // upper address bits wrap, like the 8 KB part on the board
    assign load_idx = rom_load.index[ADDR_W-1:0];
    assign rd_idx   = fetch_addr[ADDR_W-1:0];

    always_ff @(posedge clk_24M) begin
        if (rom_load.en) begin
            mem[load_idx] <= rom_load.data;
        end
    end

    // read every cycle, one clock of latency
    always_ff @(posedge clk_24M) begin
        rom_q <= mem[rd_idx];
    end

endmodule

// File: verilog/prot_decrypt.sv
// protection decrypter
// rom and adj holding registers and the key subtraction

module prot_decrypt
    import tc_prot_pkg::*;
(
    input  logic       clk_24M,
    input  logic       reset,
    input  capture_t   capture,
    input  logic [7:0] rom_q,
    output logic [7:0] decrypted
);

    logic [7:0] rom_val;
    logic [7:0] adj_val;

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            rom_val <= 8'h00;
            adj_val <= 8'h00;
        end else if (capture.en) begin
            if (capture.target == TGT_ADJ) begin
                adj_val <= rom_q;
            end else begin
                rom_val <= rom_q;
            end
        end
    end

    // rom - (key - adj), 8-bit wraparound
    // both holding registers at zero give 0xBD
    assign decrypted = rom_val - (PROT_KEY - adj_val);

endmodule

// File: verilog/dac_mixer.sv
// sound DAC mixer
// two offset-binary DACs at half scale summed with the FM sample

module dac_mixer
    import tc_prot_pkg::*;
(
    input  logic               clk_24M,
    input  logic               reset,
    input  dac_wr_t            dac_wr,
    input  logic signed [15:0] fm_sample,
    output logic signed [15:0] audio
);

    logic [7:0]         dac1;
    logic [7:0]         dac2;
    logic signed [15:0] mix;

    // offset binary to signed, upper byte, then halved
    function automatic logic signed [15:0] dac_half(input logic [7:0] val);
        logic signed [15:0] wide;
        wide = $signed({~val[7], val[6:0], 8'h00});
        return wide >>> 1;
    endfunction

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            // 0x80 sits at the midpoint
            dac1 <= 8'h80;
            dac2 <= 8'h80;
        end else if (dac_wr.en) begin
            if (dac_wr.sel) begin
                dac2 <= dac_wr.data;
            end else begin
                dac1 <= dac_wr.data;
            end
        end
    end

    assign mix = fm_sample + dac_half(dac1) + dac_half(dac2);

    always_ff @(posedge clk_24M) begin
        audio <= mix;
    end

endmodule

// File: verilog/prot_bus_ctrl.sv
// protection bus controller
// AXI4-Lite slave, register decode, ROM load strobes and the
// two-cycle fetch sequencer behind REG_DATA

module prot_bus_ctrl
    import tc_prot_pkg::*;
(
    input  logic        clk_24M,
    input  logic        reset,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    input  logic [7:0]  decrypted,
    output rom_load_t   rom_load,
    output logic [15:0] fetch_addr,
    output capture_t    capture,
    output dac_wr_t     dac_wr
);

    logic                  aw_ready_q;
    logic                  ar_ready_q;
    logic                  bvalid_q;
    logic                  rvalid_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    logic [AXI_DATA_W-1:0] rd_mux;

    logic                  wr_go;
    logic                  rd_go;
    logic                  win_wr;
    logic                  cmd_go;
    logic                  data_go;
    logic                  dac_go;

    logic [7:0]            cmd_q;
    logic [15:0]           fetch_addr_q;
    fetch_state_e          state_q;
    fetch_target_e         tgt_q;
    logic [7:0]            dac1_q;
    logic [7:0]            dac2_q;

    logic                  cmd_known;
    logic                  cmd_hi;
    fetch_target_e         cmd_tgt;

    // ==================================================
    // AXI4-Lite handshakes
    // ==================================================

    // ready pulses for one cycle and stays low while a response waits
    assign wr_go = aw_ready_q & axil_req.awvalid & axil_req.wvalid;
    assign rd_go = ar_ready_q & axil_req.arvalid;

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            aw_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
        end else begin
            aw_ready_q <= ~aw_ready_q & axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
            if (wr_go) begin
                bvalid_q <= 1'b1;
            end else if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_24M) begin
        if (reset) begin
            ar_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            ar_ready_q <= ~ar_ready_q & axil_req.arvalid & ~rvalid_q;
            if (rd_go) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // read data captured at accept and held until rready
    always_ff @(posedge clk_24M) begin
        if (rd_go) begin
            rdata_q <= rd_mux;
        end
    end

    // ROM window and unmapped offsets read as all ones
    always_comb begin
        case (axil_req.araddr)
            REG_CMD:    rd_mux = {24'h0, cmd_q};
            REG_DATA:   rd_mux = {24'h0, decrypted};
            REG_DAC1:   rd_mux = {24'h0, dac1_q};
            REG_DAC2:   rd_mux = {24'h0, dac2_q};
            REG_STATUS: rd_mux = {31'h0, state_q != FETCH_IDLE};
            default:    rd_mux = '1;
        endcase
    end

    assign axil_rsp = '{
        awready: aw_ready_q,
        wready:  aw_ready_q,
        bresp:   AXI_RESP_OKAY,
        bvalid:  bvalid_q,
        arready: ar_ready_q,
        rdata:   rdata_q,
        rresp:   AXI_RESP_OKAY,
        rvalid:  rvalid_q
    };

    // ==================================================
    // write decode
    // ==================================================
    assign win_wr  = wr_go & axil_req.awaddr[ROM_WIN_BIT];
    assign cmd_go  = wr_go & (axil_req.awaddr == REG_CMD);
    assign data_go = wr_go & (axil_req.awaddr == REG_DATA);
    assign dac_go  = wr_go & ((axil_req.awaddr == REG_DAC1) | (axil_req.awaddr == REG_DAC2));

    // ROM index is the word address inside the window
    assign rom_load = '{
        en:    win_wr,
        index: {3'b000, axil_req.awaddr[ROM_WIN_BIT-1:2]},
        data:  axil_req.wdata[7:0]
    };

    assign dac_wr = '{
        en:   dac_go,
        sel:  axil_req.awaddr == REG_DAC2,
        data: axil_req.wdata[7:0]
    };

    // opcode decode
    always_comb begin
        cmd_known = 1'b1;
        cmd_hi    = 1'b0;
        cmd_tgt   = TGT_ROM;
        case (cmd_q)
            CMD_ROM_HI: cmd_hi = 1'b1;
            CMD_ROM_LO: cmd_hi = 1'b0;
            CMD_ADJ_HI: begin
                cmd_hi  = 1'b1;
                cmd_tgt = TGT_ADJ;
            end
            CMD_ADJ_LO: cmd_tgt = TGT_ADJ;
            default:    cmd_known = 1'b0;
        endcase
    end

    // ==================================================
    // command register and fetch sequencer
    // ==================================================
    always_ff @(posedge clk_24M) begin
        if (reset) begin
            cmd_q        <= 8'h00;
            fetch_addr_q <= 16'h0000;
            state_q      <= FETCH_IDLE;
            tgt_q        <= TGT_ROM;
            dac1_q       <= 8'h80;
            dac2_q       <= 8'h80;
        end else begin
            if (cmd_go) begin
                cmd_q <= axil_req.wdata[7:0];
            end

            // mirror of the mixer DACs for readback
            if (dac_go && !dac_wr.sel) begin
                dac1_q <= axil_req.wdata[7:0];
            end
            if (dac_go && dac_wr.sel) begin
                dac2_q <= axil_req.wdata[7:0];
            end

            case (state_q)
                FETCH_WAIT:    state_q <= FETCH_CAPTURE;
                FETCH_CAPTURE: state_q <= FETCH_IDLE;
                default: begin
                    // data writes while busy or under a foreign opcode are dropped
                    if (data_go && cmd_known) begin
                        if (cmd_hi) begin
                            fetch_addr_q[15:8] <= axil_req.wdata[7:0];
                        end else begin
                            fetch_addr_q[7:0] <= axil_req.wdata[7:0];
                        end
                        tgt_q   <= cmd_tgt;
                        state_q <= FETCH_WAIT;
                    end
                end
            endcase
        end
    end

    assign fetch_addr = fetch_addr_q;

    // ROM data is valid once the wait cycle has passed
    assign capture = '{
        en:     state_q == FETCH_CAPTURE,
        target: tgt_q
    };

endmodule

// File: verilog/tc_prot_top.sv
// NB1412M2 protection chip and sound DAC mixer
// AXI4-Lite slave in front of the protection ROM, decrypter and mixer

module tc_prot_top
    import tc_prot_pkg::*;
#(
    parameter int ROM_DEPTH = 8192
) (
    input  logic               clk_24M,
    input  logic               reset,
    input  axil_req_t          axil_req,
    output axil_rsp_t          axil_rsp,
    input  logic signed [15:0] fm_sample,
    output logic signed [15:0] audio
);

    rom_load_t   rom_load;
    logic [15:0] fetch_addr;
    capture_t    capture;
    dac_wr_t     dac_wr;
    logic [7:0]  rom_q;
    logic [7:0]  decrypted;

    prot_bus_ctrl u_bus_ctrl (
        .clk_24M    (clk_24M),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .decrypted  (decrypted),
        .rom_load   (rom_load),
        .fetch_addr (fetch_addr),
        .capture    (capture),
        .dac_wr     (dac_wr)
    );

    prot_rom #(
        .ROM_DEPTH (ROM_DEPTH)
    ) u_rom (
        .clk_24M    (clk_24M),
        .rom_load   (rom_load),
        .fetch_addr (fetch_addr),
        .rom_q      (rom_q)
    );

    prot_decrypt u_decrypt (
        .clk_24M   (clk_24M),
        .reset     (reset),
        .capture   (capture),
        .rom_q     (rom_q),
        .decrypted (decrypted)
    );

    dac_mixer u_mixer (
        .clk_24M   (clk_24M),
        .reset     (reset),
        .dac_wr    (dac_wr),
        .fm_sample (fm_sample),
        .audio     (audio)
    );

endmodule

// File: sim/tc_prot_assertions.sv
// AXI4-Lite response assertions for the protection bus controller
// valid held until ready, stable payloads, OKAY responses

module tc_prot_assertions
    import tc_prot_pkg::*;
(
    input logic      clk_24M,
    input logic      reset,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp
);

    int failures = 0;

    b_held: assert property (@(posedge clk_24M) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else begin
            failures++;
            $error("bvalid or bresp changed before bready");
        end

    r_held: assert property (@(posedge clk_24M) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else begin
            failures++;
            $error("rvalid or rdata changed before rready");
        end

    // no new request accepted while a response is pending
    aw_gated: assert property (@(posedge clk_24M) disable iff (reset)
        axil_rsp.awready |-> !axil_rsp.bvalid)
        else begin
            failures++;
            $error("awready raised with bvalid pending");
        end

    ar_gated: assert property (@(posedge clk_24M) disable iff (reset)
        axil_rsp.arready |-> !axil_rsp.rvalid)
        else begin
            failures++;
            $error("arready raised with rvalid pending");
        end

    resp_okay: assert property (@(posedge clk_24M) disable iff (reset)
        (axil_rsp.bvalid |-> axil_rsp.bresp == AXI_RESP_OKAY) and
        (axil_rsp.rvalid |-> axil_rsp.rresp == AXI_RESP_OKAY))
        else begin
            failures++;
            $error("response other than OKAY");
        end

endmodule

// File: sim/tc_prot_checker.sv
// response and audio checker for the protection model
// compares read completions and audio samples and tracks open requests

module tc_prot_checker
    import tc_prot_pkg::*;
(
    input  logic               clk_24M,
    input  logic               reset,
    input  axil_req_t          axil_req,
    input  axil_rsp_t          axil_rsp,
    input  logic signed [15:0] audio,
    input  logic signed [15:0] exp_audio,
    input  logic [31:0]        exp_rdata,
    input  logic [31:0]        exp_mask,
    input  logic [8*16-1:0]    exp_name,
    output int                 errors
);

    int          error_count = 0;
    int          rd_open = 0;
    int          wr_open = 0;
    logic        rd_held = 1'b0;
    logic [31:0] rd_last;

    assign errors = error_count;

    always @(posedge clk_24M) begin
        if (reset) begin
            rd_open = 0;
            wr_open = 0;
            rd_held = 1'b0;
        end else begin
            if (audio !== exp_audio) begin
                $display("FAILED audio: expected %h actual %h", exp_audio, audio);
                error_count++;
            end

            // ==================================================
            // write channel
            // ==================================================
            if (axil_rsp.wready !== axil_rsp.awready) begin
                $display("awready and wready did not rise together");
                error_count++;
            end
            if (axil_rsp.awready && axil_rsp.wready &&
                axil_req.awvalid && axil_req.wvalid) begin
                wr_open++;
            end
            if (axil_rsp.bvalid && axil_req.bready) begin
                if (wr_open == 0) begin
                    $display("write response arrived with no write outstanding");
                    error_count++;
                end else begin
                    wr_open--;
                end
                if (axil_rsp.bresp !== AXI_RESP_OKAY) begin
                    $display("FAILED bresp: expected %h actual %h",
                             AXI_RESP_OKAY, axil_rsp.bresp);
                    error_count++;
                end
            end

            // ==================================================
            // read channel
            // ==================================================
            if (axil_rsp.arready && axil_req.arvalid) begin
                rd_open++;
            end
            if (rd_held) begin
                if (!axil_rsp.rvalid) begin
                    $display("read response withdrawn before rready");
                    error_count++;
                end else if (axil_rsp.rdata !== rd_last) begin
                    $display("read data changed while waiting for rready");
                    error_count++;
                end
            end
            if (axil_rsp.rvalid && axil_req.rready) begin
                if (rd_open == 0) begin
                    $display("read response arrived with no read outstanding");
                    error_count++;
                end else begin
                    rd_open--;
                end
                if ((axil_rsp.rdata & exp_mask) !== (exp_rdata & exp_mask)) begin
                    $display("FAILED %0s: expected %h actual %h", exp_name,
                             exp_rdata & exp_mask, axil_rsp.rdata & exp_mask);
                    error_count++;
                end
                if (axil_rsp.rresp !== AXI_RESP_OKAY) begin
                    $display("FAILED rresp: expected %h actual %h",
                             AXI_RESP_OKAY, axil_rsp.rresp);
                    error_count++;
                end
            end
            rd_held = axil_rsp.rvalid && !axil_req.rready;
            rd_last = axil_rsp.rdata;
        end
    end

endmodule

// File: sim/tc_prot_tb.sv
// testbench for the NB1412M2 protection model
// AXI4-Lite stimulus, reference model of ROM, decrypter and mixer

module tc_prot_tb
    import tc_prot_pkg::*;
;

    localparam logic [31:0] SEED = 32'h441a52f5;
    localparam int CYCLE_LIMIT = 3000;

    logic               clk_24M = 1'b0;
    logic               reset;
    logic [15:0]        awaddr;
    logic [15:0]        araddr;
    logic [31:0]        wdata;
    logic               awvalid;
    logic               wvalid;
    logic               arvalid;
    logic               bready;
    logic               rready;
    axil_req_t          axil_req;
    axil_rsp_t          axil_rsp;
    logic signed [15:0] fm_sample;
    logic signed [15:0] audio;
    logic signed [15:0] exp_audio;
    logic [31:0]        exp_rdata;
    logic [31:0]        exp_mask;
    logic [8*16-1:0]    exp_name;

    // reference model state
    logic [7:0]  rom_img [8192];
    logic [7:0]  hi_set [8];
    logic [7:0]  lo_set [8];
    logic [15:0] mdl_addr;
    logic [7:0]  mdl_rom;
    logic [7:0]  mdl_adj;
    logic [7:0]  mdl_dac1;
    logic [7:0]  mdl_dac2;

    logic [31:0] rnd_state;
    logic [31:0] noise_state;
    int          cycle_count = 0;
    int          checker_errors;
    int          assert_errors;

    assign axil_req = '{awaddr: awaddr, awvalid: awvalid, wdata: wdata, wstrb: 4'hF,
                        wvalid: wvalid, bready: bready, araddr: araddr,
                        arvalid: arvalid, rready: rready};

    tc_prot_top #(
        .ROM_DEPTH (8192)
    ) DUT (
        .clk_24M   (clk_24M),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .fm_sample (fm_sample),
        .audio     (audio)
    );

    tc_prot_checker u_checker (
        .clk_24M   (clk_24M),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .audio     (audio),
        .exp_audio (exp_audio),
        .exp_rdata (exp_rdata),
        .exp_mask  (exp_mask),
        .exp_name  (exp_name),
        .errors    (checker_errors)
    );

    bind prot_bus_ctrl tc_prot_assertions u_assert (
        .clk_24M  (clk_24M),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    always #5 clk_24M = ~clk_24M;

    // ==================================================
    // random source and reference functions
    // ==================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    // rom + adj - key, low byte
    function automatic logic [7:0] decrypt_ref(input logic [7:0] rom, input logic [7:0] adj);
        int v;
        v = int'(rom) + int'(adj) - int'(PROT_KEY);
        return v[7:0];
    endfunction

    // each DAC adds (code - 128) * 128 to the FM sample
    function automatic logic signed [15:0] mix_ref(input logic signed [15:0] fm,
                                                   input logic [7:0] d1, input logic [7:0] d2);
        int sum;
        sum = int'(fm) + (int'(d1) - 128) * 128 + (int'(d2) - 128) * 128;
        return sum[15:0];
    endfunction

    // back-pressure and FM samples on the falling edge
    always @(negedge clk_24M) begin
        noise_state = xorshift32(noise_state);
        bready      = noise_state[4] | noise_state[11];
        rready      = noise_state[7] | noise_state[19];
        fm_sample   = noise_state[31:16];
    end

    // DAC model follows accepted writes, audio one clock behind
    always @(posedge clk_24M) begin
        if (reset) begin
            mdl_dac1 <= 8'h80;
            mdl_dac2 <= 8'h80;
        end else if (axil_rsp.awready && awvalid && wvalid) begin
            if (awaddr == REG_DAC1) begin
                mdl_dac1 <= wdata[7:0];
            end
            if (awaddr == REG_DAC2) begin
                mdl_dac2 <= wdata[7:0];
            end
        end
        exp_audio <= mix_ref(fm_sample, mdl_dac1, mdl_dac2);
    end

    always @(posedge clk_24M) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_24M);
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    // ==================================================
    // bus tasks
    // ==================================================
    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
        @(negedge clk_24M);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clk_24M); while (!axil_rsp.awready);
        @(negedge clk_24M);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge clk_24M); while (!(axil_rsp.bvalid && bready));
    endtask

    task automatic axi_read(input logic [15:0] addr, input logic [31:0] exp,
                            input logic [31:0] mask, input logic [8*16-1:0] name,
                            output logic [31:0] data);
        @(negedge clk_24M);
        araddr    = addr;
        arvalid   = 1'b1;
        exp_rdata = exp;
        exp_mask  = mask;
        exp_name  = name;
        do @(posedge clk_24M); while (!axil_rsp.arready);
        @(negedge clk_24M);
        arvalid = 1'b0;
        do @(posedge clk_24M); while (!(axil_rsp.rvalid && rready));
        data = axil_rsp.rdata;
    endtask

    task automatic check_read(input logic [15:0] addr, input logic [31:0] exp,
                              input logic [8*16-1:0] name);
        logic [31:0] unused;
        axi_read(addr, exp, '1, name, unused);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        do axi_read(REG_STATUS, 32'h0, 32'h0, "status_poll", status); while (status[0]);
    endtask

    // sel 0..3 maps onto CMD_ROM_HI..CMD_ADJ_LO
    task automatic prot_op(input logic [1:0] sel, input logic [7:0] data, input bit check);
        logic [7:0]  cmd;
        logic [31:0] rv;
        cmd = CMD_ROM_HI + 8'(sel);
        rv  = next_rand();
        axi_write(REG_CMD, {24'h0, cmd});
        axi_write(REG_DATA, {rv[31:8], data});
        if (!sel[0]) begin
            mdl_addr[15:8] = data;
        end else begin
            mdl_addr[7:0] = data;
        end
        if (sel[1]) begin
            mdl_adj = rom_img[mdl_addr[12:0]];
        end else begin
            mdl_rom = rom_img[mdl_addr[12:0]];
        end
        wait_idle();
        if (check) begin
            check_read(REG_DATA, {24'h0, decrypt_ref(mdl_rom, mdl_adj)}, "rom_fetch");
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        logic [31:0] rv;
        logic [12:0] idx;
        logic [7:0]  cmd;
        logic [7:0]  d1;
        logic [7:0]  d2;

        rnd_state   = SEED;
        noise_state = xorshift32(SEED);
        reset       = 1'b1;
        awaddr      = '0;
        araddr      = '0;
        wdata       = '0;
        awvalid     = 1'b0;
        wvalid      = 1'b0;
        arvalid     = 1'b0;
        bready      = 1'b0;
        rready      = 1'b0;
        fm_sample   = '0;
        exp_rdata   = '0;
        exp_mask    = '0;
        exp_name    = "idle";
        mdl_addr    = '0;
        mdl_rom     = '0;
        mdl_adj     = '0;
        repeat (8) @(posedge clk_24M);
        @(negedge clk_24M);
        reset = 1'b0;

        check_read(REG_DATA, 32'h0000_00BD, "reset_data");
        check_read(REG_STATUS, 32'h0, "reset_status");
        check_read(REG_CMD, 32'h0, "reset_cmd");

        // 8 x 8 grid of loaded entries, any hi/lo pair hits a known byte
        for (int i = 0; i < 8; i++) begin
            rv        = next_rand();
            hi_set[i] = {rv[7:5], i[2:0], rv[1:0]};
            lo_set[i] = {rv[12:8], i[2:0]};
        end
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                rv           = next_rand();
                idx          = {hi_set[i][4:0], lo_set[j]};
                rom_img[idx] = rv[7:0];
                axi_write({1'b1, idx, 2'b00}, rv);
            end
        end

        // first fetch may land outside the grid
        prot_op(2'd1, lo_set[0], 1'b0);
        prot_op(2'd0, hi_set[0], 1'b1);
        for (int n = 0; n < 24; n++) begin
            rv = next_rand();
            prot_op(rv[1:0], rv[0] ? lo_set[rv[4:2]] : hi_set[rv[4:2]], 1'b1);
        end

        // opcodes outside the four leave everything alone
        for (int k = 0; k < 2; k++) begin
            cmd = (k == 0) ? 8'h55 : 8'h00;
            axi_write(REG_CMD, {24'h0, cmd});
            check_read(REG_CMD, {24'h0, cmd}, "cmd_readback");
            axi_write(REG_DATA, next_rand());
            wait_idle();
            check_read(REG_DATA, {24'h0, decrypt_ref(mdl_rom, mdl_adj)}, "foreign_cmd");
        end
        prot_op(2'd2, hi_set[3], 1'b1);

        for (int k = 0; k < 12; k++) begin
            rv = next_rand();
            d1 = rv[7:0];
            d2 = rv[15:8];
            axi_write(REG_DAC1, {rv[31:16], 8'h00, d1});
            axi_write(REG_DAC2, {rv[23:0], d2});
            check_read(REG_DAC1, {24'h0, d1}, "dac1_readback");
            check_read(REG_DAC2, {24'h0, d2}, "dac2_readback");
        end

        check_read(16'h0014, '1, "unmapped");
        check_read(16'h0100, '1, "unmapped");
        check_read(16'h7FFC, '1, "unmapped");
        check_read(16'h8000, '1, "rom_window");
        check_read({1'b1, hi_set[1][4:0], lo_set[2], 2'b00}, '1, "rom_window");
        axi_write(16'h0200, next_rand());

        repeat (4) @(posedge clk_24M);
        assert_errors = DUT.u_bus_ctrl.u_assert.failures;
        $display("errors: checker %0d, assertions %0d", checker_errors, assert_errors);
        if (checker_errors == 0 && assert_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/tc_prot_pkg.sv
verilog/prot_rom.sv
verilog/prot_decrypt.sv
verilog/dac_mixer.sv
verilog/prot_bus_ctrl.sv
verilog/tc_prot_top.sv
sim/tc_prot_assertions.sv
sim/tc_prot_checker.sv
sim/tc_prot_tb.sv
